//--- common/stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pattern source shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package stream_pkg;

    // beat payload width, one word
    localparam int data_width = 32;

    // width of the finished frame counter
    localparam int stat_width = 16;

    // pattern selection for the generator
    // range counts up from the start value
    // repeat sends the start value on every beat
    typedef enum logic [0:0] {
        mode_range  = 1'b0,
        mode_repeat = 1'b1
    } pattern_mode_t;

endpackage

//--- common/beat_stream_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// beat stream interface
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface beat_stream_if;

    // one word of payload per beat
    logic [stream_pkg::data_width-1:0] data;
    // beat present, held until it transfers
    logic valid;
    // sink can take a beat
    logic ready;
    // marks the final beat of a frame
    logic last;

    // source side
    modport master (
        output data,
        output valid,
        output last,
        input  ready
    );

    // sink side
    modport slave (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

//--- generator/origin_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame pattern generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module origin_gen #(
    parameter stream_pkg::pattern_mode_t MODE = stream_pkg::mode_range
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            abort,
    input  logic                            enable,
    output logic                            ready,
    input  logic [stream_pkg::data_width-1:0] start,
    input  logic [stream_pkg::data_width-1:0] length,
    beat_stream_if.master                   out_stream
);

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_sending = 2'd1,
        st_done    = 2'd2
    } gen_state_t;

    gen_state_t state;
    gen_state_t next_state;

    // latched frame length and index of the current beat
    logic [stream_pkg::data_width-1:0] len_q;
    logic [stream_pkg::data_width-1:0] beat_cnt;
    logic [stream_pkg::data_width-1:0] next_cnt;

    logic take;
    logic xfer;

    // host handshake, abort kills a start on the same edge
    assign take = enable && ready && !abort;

    // output beat accepted downstream
    assign xfer = out_stream.valid && out_stream.ready;

    assign next_cnt = beat_cnt + 1'b1;

    // only idle accepts a new frame
    assign ready = (state == st_idle);

    // a beat is on offer for the whole sending state
    assign out_stream.valid = (state == st_sending);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (take) begin
                    next_state = st_sending;
                end
            end
            st_sending: begin
                // final beat gone, back to idle on this edge
                if (xfer && out_stream.last) begin
                    next_state = st_idle;
                end
            end
            st_done: begin
                // one quiet cycle, then open for the next frame
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
        // abort drops whatever is in flight
        if (abort) begin
            next_state = st_done;
        end
    end

    // reset parks in done so ready comes up one cycle after release
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= st_done;
        end else begin
            state <= next_state;
        end
    end

    // last flag
    always_ff @(posedge clock) begin
        if (rst) begin
            out_stream.last <= 1'b0;
        end else if (abort) begin
            out_stream.last <= 1'b0;
        end else if (take) begin
            // length 0 or 1 is a single beat frame
            out_stream.last <= (length <= 1);
        end else if (xfer) begin
            if (out_stream.last) begin
                out_stream.last <= 1'b0;
            end else begin
                // next beat is the final one
                out_stream.last <= (next_cnt == len_q - 1'b1);
            end
        end
    end

    // payload, length and beat index
    always_ff @(posedge clock) begin
        if (take) begin
            out_stream.data <= start;
            len_q           <= length;
            beat_cnt        <= '0;
        end else if (xfer && !out_stream.last) begin
            beat_cnt <= next_cnt;
            // range steps by one and wraps at the word width
            // repeat keeps the start value taken at enable
            if (MODE == stream_pkg::mode_range) begin
                out_stream.data <= out_stream.data + 1'b1;
            end else begin
                out_stream.data <= out_stream.data;
            end
        end
    end

endmodule

//--- hdl/stream_slice.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two entry register slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module stream_slice (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            flush,
    beat_stream_if.slave                    in_stream,
    output logic [stream_pkg::data_width-1:0] out_data,
    output logic                            out_valid,
    output logic                            out_last,
    input  logic                            out_ready
);

    // skid entry, holds a beat caught while the output stalls
    logic [stream_pkg::data_width-1:0] skid_data;
    logic                              skid_last;
    logic                              skid_valid;

    logic in_xfer;
    logic main_load;

    // input ready only looks at the skid entry
    // so out_ready never reaches the input combinationally
    assign in_stream.ready = !skid_valid;

    assign in_xfer = in_stream.valid && in_stream.ready;

    // main entry free or draining this edge
    assign main_load = !out_valid || out_ready;

    // occupancy
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // skid has the older beat, it goes first
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_xfer;
            end
        end else if (in_xfer) begin
            // output stalled, park the new beat
            skid_valid <= 1'b1;
        end
    end

    // payload moves
    always_ff @(posedge clock) begin
        if (main_load) begin
            if (skid_valid) begin
                out_data <= skid_data;
                out_last <= skid_last;
            end else if (in_xfer) begin
                out_data <= in_stream.data;
                out_last <= in_stream.last;
            end
        end else if (in_xfer) begin
            skid_data <= in_stream.data;
            skid_last <= in_stream.last;
        end
    end

endmodule

//--- hdl/frame_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output frame statistics
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module frame_monitor (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            abort,
    input  logic [stream_pkg::data_width-1:0] beat_data,
    input  logic                            beat_valid,
    input  logic                            beat_ready,
    input  logic                            beat_last,
    output logic                            stat_valid,
    output logic [stream_pkg::data_width-1:0] stat_beats,
    output logic [stream_pkg::data_width-1:0] stat_sum,
    output logic [stream_pkg::stat_width-1:0] frame_count
);

    // totals of the frame in progress
    logic [stream_pkg::data_width-1:0] run_beats;
    logic [stream_pkg::data_width-1:0] run_sum;

    logic xfer;
    logic frame_end;

    assign xfer      = beat_valid && beat_ready;
    assign frame_end = xfer && beat_last && !abort;

    // running totals, abort throws away a partial frame
    always_ff @(posedge clock) begin
        if (rst || abort) begin
            run_beats <= '0;
            run_sum   <= '0;
        end else if (xfer) begin
            if (beat_last) begin
                run_beats <= '0;
                run_sum   <= '0;
            end else begin
                run_beats <= run_beats + 1'b1;
                // sum wraps at the word width
                run_sum   <= run_sum + beat_data;
            end
        end
    end

    // one cycle strobe and finished frame count
    always_ff @(posedge clock) begin
        if (rst) begin
            stat_valid  <= 1'b0;
            frame_count <= '0;
        end else begin
            stat_valid <= frame_end;
            if (frame_end) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // published totals include the last beat
    // held until the next frame ends
    always_ff @(posedge clock) begin
        if (frame_end) begin
            stat_beats <= run_beats + 1'b1;
            stat_sum   <= run_sum + beat_data;
        end
    end

endmodule

//--- hdl/pattern_source_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream pattern source top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pattern_source_top #(
    parameter stream_pkg::pattern_mode_t MODE = stream_pkg::mode_range
) (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            abort,
    // host frame request
    input  logic                            enable,
    output logic                            ready,
    input  logic [stream_pkg::data_width-1:0] start,
    input  logic [stream_pkg::data_width-1:0] length,
    // output stream
    output logic [stream_pkg::data_width-1:0] out_data,
    output logic                            out_valid,
    output logic                            out_last,
    input  logic                            out_ready,
    // per frame statistics
    output logic                            stat_valid,
    output logic [stream_pkg::data_width-1:0] stat_beats,
    output logic [stream_pkg::data_width-1:0] stat_sum,
    output logic [stream_pkg::stat_width-1:0] frame_count
);

    // generator to slice
    beat_stream_if gen_to_slice ();

    origin_gen #(
        .MODE (MODE)
    ) u_origin_gen (
        .clock      (clock),
        .rst        (rst),
        .abort      (abort),
        .enable     (enable),
        .ready      (ready),
        .start      (start),
        .length     (length),
        .out_stream (gen_to_slice.master)
    );

    // abort also empties the slice
    stream_slice u_stream_slice (
        .clock     (clock),
        .rst       (rst),
        .flush     (abort),
        .in_stream (gen_to_slice.slave),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    // taps the output handshake
    frame_monitor u_frame_monitor (
        .clock       (clock),
        .rst         (rst),
        .abort       (abort),
        .beat_data   (out_data),
        .beat_valid  (out_valid),
        .beat_ready  (out_ready),
        .beat_last   (out_last),
        .stat_valid  (stat_valid),
        .stat_beats  (stat_beats),
        .stat_sum    (stat_sum),
        .frame_count (frame_count)
    );

endmodule

//--- testbench/tb_pattern_source.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pattern source testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_pattern_source;

    logic        clock;
    logic        rst;
    logic        abort;
    logic        enable;
    logic        out_ready;
    logic [31:0] start;
    logic [31:0] length;

    // range mode outputs
    logic        ready;
    logic [31:0] out_data;
    logic        out_valid;
    logic        out_last;
    logic        stat_valid;
    logic [31:0] stat_beats;
    logic [31:0] stat_sum;
    logic [15:0] frame_count;

    // repeat mode outputs
    logic        rep_ready;
    logic [31:0] rep_data;
    logic        rep_valid;
    logic        rep_last;
    logic        rep_stat_valid;
    logic [31:0] rep_stat_beats;
    logic [31:0] rep_stat_sum;
    logic [15:0] rep_frame_count;

    // expected beats not yet taken at the output
    logic [31:0] q_range[$];
    logic [31:0] q_rep[$];
    logic        q_last[$];

    // running and finished frame totals of the model
    logic [31:0] run_beats;
    logic [31:0] run_sum;
    logic [31:0] run_sum_rep;
    logic [31:0] due_beats;
    logic [31:0] due_sum;
    logic [31:0] due_sum_rep;
    logic        stat_due;
    int          frames_done;

    // generator and slice occupancy of the model
    bit          gen_busy;
    // generator parked for one cycle after reset or abort
    bit          gen_hold;
    int          gen_left;
    int          slice_cnt;

    // stimulus state
    logic [31:0] lfsr_state;
    int          frames_left;
    int          gap;
    int          abort_wait;
    bit          hold_enable;
    bit          stall_on;

    // outputs seen at the last falling edge
    logic        seen_ready;
    logic        seen_valid;
    logic        seen_stat;
    logic [15:0] seen_count;

    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    pattern_source_top #(
        .MODE (stream_pkg::mode_range)
    ) UUT (
        .clock (clock), .rst (rst), .abort (abort), .enable (enable),
        .ready (ready), .start (start), .length (length),
        .out_data (out_data), .out_valid (out_valid), .out_last (out_last),
        .out_ready (out_ready), .stat_valid (stat_valid), .stat_beats (stat_beats),
        .stat_sum (stat_sum), .frame_count (frame_count)
    );

    // same inputs and only the payload differs
    pattern_source_top #(
        .MODE (stream_pkg::mode_repeat)
    ) UUT_REPEAT (
        .clock (clock), .rst (rst), .abort (abort), .enable (enable),
        .ready (rep_ready), .start (start), .length (length),
        .out_data (rep_data), .out_valid (rep_valid), .out_last (rep_last),
        .out_ready (out_ready), .stat_valid (rep_stat_valid),
        .stat_beats (rep_stat_beats), .stat_sum (rep_stat_sum),
        .frame_count (rep_frame_count)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function logic [31:0] rand_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task stop_on_timeout(input string what);
        $display("TIMEOUT %0t %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task new_request;
        start  <= rand_bits(32);
        length <= rand_bits(5) % 21;
    endtask

    function automatic bit settled();
        return frames_left == 0 && q_range.size() == 0 && seen_ready &&
               !gen_hold && abort_wait < 0 && !stat_due;
    endfunction

    // check at the falling edge then update the model and drive at the rising edge
    task run_cycle;
        logic        s_abort;
        logic        s_xfer;
        logic        s_take;
        logic        s_push;
        logic        want_ready;
        logic        want_valid;
        logic [31:0] s_start;
        logic [31:0] s_len;
        logic [31:0] d_range;
        logic [31:0] d_rep;
        logic        d_last;
        int          n;
        @(negedge clock);
        // generator takes a frame only when idle
        want_ready = !gen_busy && !gen_hold;
        // slice shows a beat whenever it holds one
        want_valid = (slice_cnt > 0);
        check_value("ready", ready, want_ready);
        check_value("repeat ready", rep_ready, want_ready);
        check_value("out_valid", out_valid, want_valid);
        check_value("repeat out_valid", rep_valid, want_valid);
        if (want_valid) begin
            check_value("out_data", out_data, q_range[0]);
            check_value("repeat out_data", rep_data, q_rep[0]);
            check_value("out_last", out_last, q_last[0]);
            check_value("repeat out_last", rep_last, q_last[0]);
        end
        check_value("stat_valid", stat_valid, stat_due);
        check_value("repeat stat_valid", rep_stat_valid, stat_due);
        if (stat_due) begin
            check_value("stat_beats", stat_beats, due_beats);
            check_value("stat_sum", stat_sum, due_sum);
            check_value("frame_count", frame_count, frames_done);
            check_value("repeat stat_beats", rep_stat_beats, due_beats);
            check_value("repeat stat_sum", rep_stat_sum, due_sum_rep);
            check_value("repeat frame_count", rep_frame_count, frames_done);
        end
        seen_ready = ready;
        seen_valid = out_valid;
        seen_stat  = stat_valid;
        seen_count = frame_count;
        s_abort = abort;
        s_xfer  = want_valid && out_ready && !abort;
        s_take  = enable && want_ready && !abort;
        // slice input open while one entry is free
        s_push  = gen_busy && (slice_cnt < 2);
        s_start = start;
        s_len   = length;

        @(posedge clock);
        stat_due = 1'b0;
        gen_hold = s_abort;
        if (s_abort) begin
            // whole frame in flight is gone
            q_range.delete();
            q_rep.delete();
            q_last.delete();
            run_beats   = '0;
            run_sum     = '0;
            run_sum_rep = '0;
            gen_busy    = 1'b0;
            slice_cnt   = 0;
        end else begin
            if (s_xfer) begin
                d_range      = q_range.pop_front();
                d_rep        = q_rep.pop_front();
                d_last       = q_last.pop_front();
                slice_cnt--;
                run_beats    = run_beats + 1;
                run_sum      = run_sum + d_range;
                run_sum_rep  = run_sum_rep + d_rep;
                if (d_last) begin
                    stat_due    = 1'b1;
                    due_beats   = run_beats;
                    due_sum     = run_sum;
                    due_sum_rep = run_sum_rep;
                    frames_done++;
                    run_beats   = '0;
                    run_sum     = '0;
                    run_sum_rep = '0;
                end
            end
            if (s_push) begin
                slice_cnt++;
                gen_left--;
                // final beat entered the slice
                if (gen_left == 0) begin
                    gen_busy = 1'b0;
                end
            end
        end
        if (s_take) begin
            // length 0 still gives one beat
            n = (s_len <= 1) ? 1 : int'(s_len);
            for (int i = 0; i < n; i++) begin
                q_range.push_back(s_start + i);
                q_rep.push_back(s_start);
                q_last.push_back(i == n - 1);
            end
            gen_busy = 1'b1;
            gen_left = n;
            frames_left--;
        end

        abort <= (abort_wait == 0);
        if (abort_wait >= 0) begin
            abort_wait--;
        end
        // about 30% stalls
        out_ready <= stall_on ? (rand_bits(4) > 4) : 1'b1;
        if (hold_enable) begin
            enable <= (frames_left > 0);
            if (s_take) begin
                new_request();
            end
        end else if (enable) begin
            // single cycle pulse that may land while busy
            enable <= 1'b0;
            gap = rand_bits(2);
        end else if (gap > 0) begin
            gap--;
        end else if (frames_left > 0) begin
            new_request();
            enable <= 1'b1;
        end
    endtask

    task run_until_settled(input string what, input int limit);
        int n;
        n = 0;
        run_cycle();
        while (!settled() && n < limit) begin
            run_cycle();
            n++;
        end
        if (!settled()) begin
            stop_on_timeout(what);
        end
    endtask

    task finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
        errors_at_start = errors;
    endtask

    initial begin
        int n;
        clock = 1'b0;
        rst = 1'b1;
        abort = 1'b0;
        enable = 1'b0;
        out_ready = 1'b0;
        start = '0;
        length = '0;
        lfsr_state = 32'h377c;
        run_beats = '0;
        run_sum = '0;
        run_sum_rep = '0;
        stat_due = 1'b0;
        frames_done = 0;
        gen_busy = 1'b0;
        gen_hold = 1'b1;
        gen_left = 0;
        slice_cnt = 0;
        frames_left = 0;
        gap = 0;
        abort_wait = -1;
        hold_enable = 1'b0;
        stall_on = 1'b0;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;

        repeat (4) @(posedge clock);
        rst       <= 1'b0;
        out_ready <= 1'b1;

        // idle state after reset
        n = 0;
        run_cycle();
        while (!seen_ready && n < 8) begin
            run_cycle();
            n++;
        end
        if (!seen_ready) begin
            stop_on_timeout("ready did not rise after reset");
        end
        check_value("out_valid after reset", seen_valid, 1'b0);
        check_value("stat_valid after reset", seen_stat, 1'b0);
        check_value("frame_count after reset", seen_count, 16'd0);
        finish_test("reset");

        // enable held high and the first frame wraps past 2^32
        hold_enable = 1'b1;
        stall_on    = 1'b0;
        start       <= 32'hffff_fff8;
        length      <= 32'd16;
        frames_left = 8;
        run_until_settled("back to back frames without stalls did not finish", 2000);
        stall_on    = 1'b1;
        frames_left = 6;
        run_until_settled("back to back frames with stalls did not finish", 2000);
        finish_test("wrap and back to back");

        // single pulses with random gaps
        hold_enable = 1'b0;
        gap         = 0;
        frames_left = 16;
        run_until_settled("random frames with back-pressure did not finish", 4000);
        finish_test("random frames with back-pressure");

        // long frame cut short and then clean frames
        hold_enable = 1'b1;
        start       <= rand_bits(32);
        length      <= 32'd20;
        frames_left = 1;
        abort_wait  = 4 + rand_bits(3);
        run_until_settled("generator did not return to idle after abort", 200);
        hold_enable = 1'b0;
        frames_left = 3;
        run_until_settled("frames after abort did not finish", 1000);
        finish_test("abort mid frame");

        $display("%0d tests, %0d failed, %0d errors, %0d frames", tests_run,
                 tests_failed, errors, frames_done);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
common/stream_pkg.sv
common/beat_stream_if.sv
generator/origin_gen.sv
hdl/stream_slice.sv
hdl/frame_monitor.sv
hdl/pattern_source_top.sv
testbench/tb_pattern_source.sv

//--- Bender.yml
package:
  name: pattern_source

sources:
  - files:
      - common/stream_pkg.sv
      - common/beat_stream_if.sv
      - generator/origin_gen.sv
      - hdl/stream_slice.sv
      - hdl/frame_monitor.sv
      - hdl/pattern_source_top.sv
  - target: test
    files:
      - testbench/tb_pattern_source.sv
